// File: include/sfp_macros.svh
/*
  sfp port timing constants
  timer width, presence debounce, fault hold and retry limit
*/
`ifndef SFP_MACROS_SVH
`define SFP_MACROS_SVH

// width of the interval timer counter
`define SFP_TIMER_W 16

// cycles of steady presence before the port goes active
`define SFP_DEBOUNCE_CYCLES 16

// cycles the laser stays forced off after a fault
`define SFP_FAULT_HOLD_CYCLES 64

// faults before lockout, count itself saturates at 15
`define SFP_MAX_RETRIES 3

`endif

// File: design/sfp_pkg.sv
/*
  sfp port shared definitions
  bus response codes, port FSM state encoding and register map addresses
*/
package sfp_pkg;

  // response codes on mm_response
  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_idle   = 2'b10,  // nothing accessed since reset
    resp_decerr = 2'b11   // unmapped address
  } mm_resp_t;

  // bring-up / fault-recovery states
  typedef enum logic [2:0] {
    st_absent     = 3'd0,
    st_settle     = 3'd1,  // presence debounce running
    st_active     = 3'd2,
    st_fault_hold = 3'd3,  // laser forced off after tx_fault
    st_lockout    = 3'd4   // too many faults, waits for sw
  } port_state_t;

  // register offsets on mm_address
  localparam logic [3:0] reg_status  = 4'h0;
  localparam logic [3:0] reg_control = 4'h1;
  localparam logic [3:0] reg_state   = 4'h2;
  localparam logic [3:0] reg_events  = 4'h3;

endpackage

// File: design/sfp_ctrl_if.sv
/*
  sfp port control interface
  carries port state and effective laser disable from the FSM to the
  register block, and sw requests back the other way
*/
`timescale 1ns/10ps

interface sfp_ctrl_if;
  import sfp_pkg::*;

  // driven by the FSM
  port_state_t state;
  logic [3:0]  fault_count;     // saturating fault counter
  logic        tx_disable_eff;  // what actually goes to the pin
  logic        present;         // FSM view of presence

  // driven by the register block
  logic        tx_disable_req;  // sw laser disable
  logic        fault_clear;     // one-cycle pulse, leaves lockout

  modport fsm (
    output state, fault_count, tx_disable_eff, present,
    input  tx_disable_req, fault_clear
  );

  modport regs (
    input  state, fault_count, tx_disable_eff, present,
    output tx_disable_req, fault_clear
  );

endinterface

// File: design/sfp_input_sync.sv
/*
  sfp status pin synchronizer
  two-flop chains for presence, los and tx_fault, presence made active high
*/
`timescale 1ns/10ps

module sfp_input_sync (
  input  logic clk,
  input  logic reset,
  input  logic los,
  input  logic mod0_prsnt_n,
  input  logic tx_fault,
  output logic present_s,
  output logic los_s,
  output logic fault_s
);

  // bit order {tx_fault, los, mod0_prsnt_n}
  localparam logic [2:0] idle_val = 3'b011;  // absent, no light, no fault

  logic [2:0] meta;  // first stage, may go metastable
  logic [2:0] sync;  // second stage, safe to use

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      meta <= idle_val;
      sync <= idle_val;
    end
    else
    begin
      meta <= {tx_fault, los, mod0_prsnt_n};
      sync <= meta;
    end
  end

  assign present_s = ~sync[0];  // pin is active low
  assign los_s     = sync[1];
  assign fault_s   = sync[2];

  a_no_x_out: assert property (@(posedge clk) disable iff (reset)
    !$isunknown({present_s, los_s, fault_s}))
    else $error("sfp_input_sync: unknown on synchronized outputs");

endmodule

// File: design/sfp_port_timer.sv
/*
  sfp interval timer
  loadable down counter, done pulses exactly length cycles after start,
  a new start restarts the count
*/
`timescale 1ns/10ps
`include "sfp_macros.svh"

module sfp_port_timer (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    start,
  input  logic [`SFP_TIMER_W-1:0] length,
  output logic                    done,
  output logic                    busy
);

  logic [`SFP_TIMER_W-1:0] cnt;  // cycles left before done

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      cnt  <= '0;
      busy <= 1'b0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;  // single-cycle pulse
      if (start)
      begin
        cnt  <= length - 1'b1;
        done <= (length == 1);          // shortest interval
        busy <= (length > 1);
      end
      else if (busy)
      begin
        cnt <= cnt - 1'b1;
        if (cnt == 1)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

  // done only ever ends an interval that was running
  a_done_needs_busy: assert property (@(posedge clk) disable iff (reset)
    $rose(done) |-> $past(busy) || $past(start))
    else $error("sfp_port_timer: done without a running interval");

  a_zero_length: assert property (@(posedge clk) disable iff (reset)
    start |-> length != 0)
    else $error("sfp_port_timer: start with zero length");

endmodule

// File: design/sfp_port_fsm.sv
/*
  sfp port bring-up and fault-recovery FSM
  debounces insertion, holds the laser off after tx_fault, locks out after
  too many faults and owns the effective laser disable
*/
`timescale 1ns/10ps
`include "sfp_macros.svh"

module sfp_port_fsm (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    present_s,
  input  logic                    los_s,
  input  logic                    fault_s,
  input  logic                    timer_done,
  output logic                    timer_start,
  output logic [`SFP_TIMER_W-1:0] timer_len,
  sfp_ctrl_if.fsm                 ctrl
);
  import sfp_pkg::*;

  localparam logic [`SFP_TIMER_W-1:0] debounce_len = `SFP_TIMER_W'(`SFP_DEBOUNCE_CYCLES);
  localparam logic [`SFP_TIMER_W-1:0] hold_len     = `SFP_TIMER_W'(`SFP_FAULT_HOLD_CYCLES);
  localparam logic [3:0]              max_retries  = 4'(`SFP_MAX_RETRIES);

  port_state_t state;
  logic [3:0]  fault_count;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      state       <= st_absent;
      fault_count <= '0;
      timer_start <= 1'b0;
      timer_len   <= debounce_len;
    end
    else
    begin
      timer_start <= 1'b0;  // start is a pulse
      if (!present_s)
      begin
        // removal wins from any state
        state       <= st_absent;
        fault_count <= '0;
      end
      else
      begin
        case (state)
          st_absent:
          begin
            state       <= st_settle;
            timer_start <= 1'b1;  // debounce from here
            timer_len   <= debounce_len;
          end
          st_settle:
          begin
            if (timer_done)
              state <= st_active;  // presence held the whole interval
          end
          st_active:
          begin
            if (fault_s)
            begin
              state       <= st_fault_hold;
              timer_start <= 1'b1;
              timer_len   <= hold_len;
              if (fault_count != 4'hf)
                fault_count <= fault_count + 4'd1;  // saturate
            end
          end
          st_fault_hold:
          begin
            if (timer_done)
              state <= (fault_count >= max_retries) ? st_lockout : st_active;
          end
          st_lockout:
          begin
            // only sw gets us out
            if (ctrl.fault_clear)
            begin
              state       <= st_settle;
              fault_count <= '0;
              timer_start <= 1'b1;
              timer_len   <= debounce_len;
            end
          end
          default: state <= st_absent;
        endcase
      end
    end
  end

  assign ctrl.state          = state;
  assign ctrl.fault_count    = fault_count;
  assign ctrl.present        = (state != st_absent);  // one cycle behind present_s
  // laser on only when active and sw allows it
  assign ctrl.tx_disable_eff = (state != st_active) | ctrl.tx_disable_req;

  a_laser_off_outside_active: assert property (@(posedge clk) disable iff (reset)
    (ctrl.state != st_active) |-> ctrl.tx_disable_eff)
    else $error("sfp_port_fsm: laser enabled outside st_active");

endmodule

// File: design/sfp_port_regs.sv
/*
  sfp port register block
  status, control, state and event registers on plain read/write strobes,
  read data one cycle after the strobe, events are write-one-to-clear
*/
`timescale 1ns/10ps

module sfp_port_regs (
  input  logic       clk,
  input  logic       reset,
  input  logic       present_s,
  input  logic       los_s,
  input  logic       fault_s,
  input  logic [3:0] mm_address,
  input  logic       mm_read,
  input  logic       mm_write,
  input  logic [7:0] mm_writedata,
  output logic [7:0] mm_readdata,
  output logic [1:0] mm_response,
  output logic [1:0] ratesel,
  sfp_ctrl_if.regs   ctrl
);
  import sfp_pkg::*;

  logic [7:0] rd_data;
  mm_resp_t   rd_resp;
  mm_resp_t   wr_resp;

  logic       tx_disable_req_r;
  logic [1:0] ratesel_r;
  logic       fault_clear_r;

  logic [3:0] events;      // {fault, los rose, removed, inserted}
  logic [3:0] ev_set;
  logic [3:0] ev_clr;
  logic       present_d;   // previous cycle values for edge detect
  logic       los_d;
  logic       fault_d;

  // sw writes
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      tx_disable_req_r <= 1'b1;  // laser off until sw says otherwise
      ratesel_r        <= 2'b00;
      fault_clear_r    <= 1'b0;
      wr_resp          <= resp_idle;
    end
    else
    begin
      fault_clear_r <= 1'b0;  // self clearing
      if (mm_write)
      begin
        case (mm_address)
          reg_control:
          begin
            tx_disable_req_r <= mm_writedata[3];
            ratesel_r        <= mm_writedata[5:4];
            fault_clear_r    <= mm_writedata[0];
            wr_resp          <= resp_okay;
          end
          reg_status, reg_state, reg_events: wr_resp <= resp_okay;  // ro / w1c
          default: wr_resp <= resp_decerr;
        endcase
      end
    end
  end

  // edges seen by the FSM and the sync stage
  assign ev_set = {fault_s & ~fault_d,
                   los_s & ~los_d,
                   ~ctrl.present & present_d,
                   ctrl.present & ~present_d};
  assign ev_clr = (mm_write && mm_address == reg_events) ? mm_writedata[3:0] : 4'b0000;

  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      events    <= 4'b0000;
      present_d <= 1'b0;
      los_d     <= 1'b1;  // matches sync reset, no event at startup
      fault_d   <= 1'b0;
    end
    else
    begin
      events    <= (events & ~ev_clr) | ev_set;  // new edge beats the clear
      present_d <= ctrl.present;
      los_d     <= los_s;
      fault_d   <= fault_s;
    end
  end

  // sw reads, data held until next mapped read
  always_ff @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      rd_data <= 8'h00;
      rd_resp <= resp_idle;
    end
    else if (mm_read)
    begin
      rd_resp <= resp_okay;
      case (mm_address)
        reg_status:
          rd_data <= {2'b00, ratesel_r, ctrl.tx_disable_eff, fault_s, los_s, present_s};
        reg_control: rd_data <= {2'b00, ratesel_r, tx_disable_req_r, 3'b000};
        reg_state:   rd_data <= {ctrl.fault_count, 1'b0, ctrl.state};
        reg_events:  rd_data <= {4'b0000, events};
        default:     rd_resp <= resp_decerr;  // data left alone
      endcase
    end
  end

  assign mm_readdata         = rd_data;
  assign mm_response         = mm_read ? rd_resp : wr_resp;
  assign ratesel             = ratesel_r;
  assign ctrl.tx_disable_req = tx_disable_req_r;
  assign ctrl.fault_clear    = fault_clear_r;

  a_no_rd_wr_overlap: assert property (@(posedge clk) disable iff (reset)
    !(mm_read && mm_write))
    else $error("sfp_port_regs: read and write strobes together");

endmodule

// File: design/sfp_port_top.sv
/*
  sfp port top level
  one cage: status sync, bring-up FSM with its timer, register block and
  open-drain pass-through of the module i2c lines
*/
`timescale 1ns/10ps
`include "sfp_macros.svh"

module sfp_port_top (
  input  logic       clk,
  input  logic       reset,
  input  logic       los,
  input  logic       mod0_prsnt_n,
  input  logic       tx_fault,
  output logic       tx_disable,
  output logic [1:0] ratesel,
  inout  tri1        mod1_scl,
  inout  tri1        mod2_sda,
  input  logic [3:0] mm_address,
  input  logic       mm_read,
  input  logic       mm_write,
  input  logic [7:0] mm_writedata,
  output logic [7:0] mm_readdata,
  output logic [1:0] mm_response,
  output logic       scl_in,      // i2c master side
  output logic       sda_in,
  input  logic       scl_oe,
  input  logic       sda_oe
);

  logic                    present_s;
  logic                    los_s;
  logic                    fault_s;
  logic                    timer_start;
  logic [`SFP_TIMER_W-1:0] timer_len;
  logic                    timer_done;

  sfp_ctrl_if ctrl ();

  sfp_input_sync u_sync (
    .clk          (clk),
    .reset        (reset),
    .los          (los),
    .mod0_prsnt_n (mod0_prsnt_n),
    .tx_fault     (tx_fault),
    .present_s    (present_s),
    .los_s        (los_s),
    .fault_s      (fault_s)
  );

  sfp_port_timer u_timer (
    .clk    (clk),
    .reset  (reset),
    .start  (timer_start),
    .length (timer_len),
    .done   (timer_done),
    .busy   ()             // fsm tracks intervals by state
  );

  sfp_port_fsm u_fsm (
    .clk         (clk),
    .reset       (reset),
    .present_s   (present_s),
    .los_s       (los_s),
    .fault_s     (fault_s),
    .timer_done  (timer_done),
    .timer_start (timer_start),
    .timer_len   (timer_len),
    .ctrl        (ctrl.fsm)
  );

  sfp_port_regs u_regs (
    .clk          (clk),
    .reset        (reset),
    .present_s    (present_s),
    .los_s        (los_s),
    .fault_s      (fault_s),
    .mm_address   (mm_address),
    .mm_read      (mm_read),
    .mm_write     (mm_write),
    .mm_writedata (mm_writedata),
    .mm_readdata  (mm_readdata),
    .mm_response  (mm_response),
    .ratesel      (ratesel),
    .ctrl         (ctrl.regs)
  );

  assign tx_disable = ctrl.tx_disable_eff;

  // open drain, tri1 pulls the line up when released
  assign mod1_scl = scl_oe ? 1'b0 : 1'bz;
  assign mod2_sda = sda_oe ? 1'b0 : 1'bz;
  assign scl_in   = mod1_scl;
  assign sda_in   = mod2_sda;

endmodule

// File: sim/sfp_port_checker.sv
/*
  sfp port checker
  watches the UUT pins and register bus, keeps a reference model of the
  sw-visible registers, compares reads, pins and port timing windows
*/
`timescale 1ns/10ps
`include "sfp_macros.svh"

module sfp_port_checker (
  input  logic       clk,
  input  logic       reset,
  input  logic [3:0] test_id,
  input  logic       los,
  input  logic       mod0_prsnt_n,
  input  logic       tx_fault,
  input  logic       tx_disable,
  input  logic [1:0] ratesel,
  input  logic [3:0] mm_address,
  input  logic       mm_read,
  input  logic       mm_write,
  input  logic [7:0] mm_writedata,
  input  logic [7:0] mm_readdata,
  input  logic [1:0] mm_response,
  input  wire        mod1_scl,
  input  wire        mod2_sda,
  input  logic       scl_in,
  input  logic       sda_in,
  input  logic       scl_oe,
  input  logic       sda_oe,
  output int         err_count
);
  import sfp_pkg::*;

  localparam int deb  = `SFP_DEBOUNCE_CYCLES;
  localparam int hold = `SFP_FAULT_HOLD_CYCLES;

  int          chk_count;
  logic [1:0]  m_ratesel;      // model of control reg
  logic        m_txdis_req;
  logic [3:0]  m_events;
  port_state_t m_state;        // settled state only
  logic [3:0]  m_count;
  logic [2:0]  m_pins;         // {fault, los, present} last seen
  logic [2:0]  pins_now;
  logic [7:0]  m_last_rd;      // decode error leaves this on the bus
  logic        rd_pend;
  logic [7:0]  rd_exp;
  logic [1:0]  rd_resp_exp;
  logic        wr_pend;
  logic [1:0]  wr_resp_exp;
  logic        reset_d;        // first edge after reset release
  logic        ins_mon;        // insertion to laser-on window
  int          ins_cnt;
  int          flt_phase;      // 0 idle, 1 waiting for rise, 2 in hold
  int          flt_cnt;
  logic        flt_hold_chk;   // hold ends back in active

  initial
  begin
    err_count = 0;
    chk_count = 0;
  end

  function automatic string test_name(input logic [3:0] id);
    case (id)
      4'd1:    test_name = "reset";
      4'd2:    test_name = "insert_remove";
      4'd3:    test_name = "register_map";
      4'd4:    test_name = "fault_lockout";
      4'd5:    test_name = "events";
      4'd6:    test_name = "i2c_passthru";
      default: test_name = "setup";
    endcase
  endfunction

  // expected read data from the model
  function automatic logic [7:0] predict_read(input logic [3:0] addr);
    logic dis_eff;
    dis_eff = (m_state != st_active) | m_txdis_req;  // laser only on when active
    case (addr)
      reg_status:  predict_read = {2'b00, m_ratesel, dis_eff, m_pins};
      reg_control: predict_read = {2'b00, m_ratesel, m_txdis_req, 3'b000};
      reg_state:   predict_read = {m_count, 1'b0, m_state};
      reg_events:  predict_read = {4'b0000, m_events};
      default:     predict_read = m_last_rd;
    endcase
  endfunction

  task automatic check_val(input string what, input logic [7:0] exp, input logic [7:0] act);
    chk_count++;
    if (act !== exp)
    begin
      err_count++;
      $display("[FAIL] %s %s exp=%h act=%h", test_name(test_id), what, exp, act);
    end
  endtask

  task automatic check_window(input string what, input int lo, input int hi, input int act);
    chk_count++;
    if (act < lo || act > hi)
    begin
      err_count++;
      $display("[FAIL] %s %s exp=%0d..%0d act=%0d", test_name(test_id), what, lo, hi, act);
    end
  endtask

  task automatic note_failure(input string msg);
    err_count++;
    $display("error in %s at %0t: %s", test_name(test_id), $time, msg);
  endtask

  task automatic print_summary();
    $display("checks %0d, errors %0d", chk_count, err_count);
  endtask

  task automatic apply_write(input logic [3:0] addr, input logic [7:0] data);
    if (addr == reg_control)
    begin
      m_txdis_req = data[3];
      m_ratesel   = data[5:4];
      if (data[0] && m_state == st_lockout)
      begin
        m_state = st_active;  // settles through debounce
        m_count = 4'd0;
      end
    end
    else if (addr == reg_events)
      m_events = m_events & ~data[3:0];  // w1c
  endtask

  always @(posedge clk or posedge reset)
  begin
    if (reset)
    begin
      m_ratesel   = 2'b00;
      m_txdis_req = 1'b1;
      m_events    = 4'b0000;
      m_state     = st_absent;
      m_count     = 4'd0;
      m_pins      = 3'b010;  // absent, no light, no fault
      m_last_rd   = 8'h00;
      rd_pend     = 1'b0;
      wr_pend     = 1'b0;
      reset_d     = 1'b1;
      ins_mon     = 1'b0;
      flt_phase   = 0;
    end
    else
    begin
      if (reset_d)
      begin
        check_val("reset response", 8'h02, {6'b0, mm_response});
        check_val("reset tx_disable", 8'h01, {7'b0, tx_disable});
      end
      reset_d = 1'b0;
      check_val("ratesel pins", {6'b0, m_ratesel}, {6'b0, ratesel});
      check_val("scl line", !scl_oe, mod1_scl);  // pulled up unless driven
      check_val("sda line", !sda_oe, mod2_sda);
      check_val("scl_in", !scl_oe, scl_in);
      check_val("sda_in", !sda_oe, sda_in);

      if (rd_pend && mm_read)  // read response visible while strobe still up
      begin
        check_val("read data", rd_exp, mm_readdata);
        check_val("read response", {6'b0, rd_resp_exp}, {6'b0, mm_response});
      end
      if (wr_pend && !mm_read)
        check_val("write response", {6'b0, wr_resp_exp}, {6'b0, mm_response});

      if (ins_mon)
      begin
        ins_cnt++;
        if (!tx_disable || ins_cnt > deb + 6)
        begin
          check_window("insert to active cycles", deb, deb + 6, ins_cnt);
          ins_mon = 1'b0;
        end
      end
      if (flt_phase == 1)
      begin
        flt_cnt++;
        if (tx_disable)
        begin
          check_window("fault to tx_disable cycles", 2, 3, flt_cnt);
          flt_phase = flt_hold_chk ? 2 : 0;  // lockout keeps it high
          flt_cnt   = 1;
        end
        else if (flt_cnt > 3)
        begin
          note_failure("tx_disable did not rise after tx_fault");
          flt_phase = 0;
        end
      end
      else if (flt_phase == 2)
      begin
        if (tx_disable && flt_cnt <= hold + 1)
          flt_cnt++;
        else
        begin
          check_window("fault hold cycles", hold, hold + 1, flt_cnt);
          flt_phase = 0;
        end
      end

      if (mm_read && !rd_pend)
      begin
        rd_exp      = predict_read(mm_address);
        rd_resp_exp = (mm_address < 4) ? 2'b00 : 2'b11;
        if (mm_address < 4)
          m_last_rd = rd_exp;
        if (mm_address == reg_status)
          check_val("tx_disable pin", rd_exp[3], tx_disable);
        rd_pend = 1'b1;
      end
      else
        rd_pend = 1'b0;  // second strobe cycle is not a new access

      wr_pend = mm_write;
      if (mm_write)
      begin
        wr_resp_exp = (mm_address < 4) ? 2'b00 : 2'b11;
        apply_write(mm_address, mm_writedata);
      end

      pins_now = {tx_fault, los, ~mod0_prsnt_n};
      if (pins_now[0] && !m_pins[0])
      begin
        m_events[0] = 1'b1;
        m_state     = st_active;
        ins_mon     = !m_txdis_req;  // window only visible with laser allowed
        ins_cnt     = 0;
      end
      if (!pins_now[0] && m_pins[0])
      begin
        m_events[1] = 1'b1;
        m_state     = st_absent;
        m_count     = 4'd0;
        ins_mon     = 1'b0;
        flt_phase   = 0;
      end
      if (pins_now[1] && !m_pins[1])
        m_events[2] = 1'b1;
      if (pins_now[2] && !m_pins[2])
      begin
        m_events[3] = 1'b1;
        if (m_state == st_active)
        begin
          if (m_count != 4'hf)
            m_count = m_count + 4'd1;
          if (m_count >= `SFP_MAX_RETRIES)
            m_state = st_lockout;
          flt_hold_chk = (m_state == st_active);
          flt_phase    = m_txdis_req ? 0 : 1;
          flt_cnt      = 0;
        end
      end
      m_pins = pins_now;
    end
  end

endmodule

// File: sim/sfp_port_tb.sv
/*
  sfp port testbench
  clock, reset, module pin and register bus stimulus, i2c master side
  drivers, watchdog, UUT and checker instances
*/
`timescale 1ns/10ps
`include "sfp_macros.svh"

module sfp_port_tb;
  import sfp_pkg::*;

  localparam int deb     = `SFP_DEBOUNCE_CYCLES;
  localparam int hold    = `SFP_FAULT_HOLD_CYCLES;
  localparam int retries = `SFP_MAX_RETRIES;
  // per test: reset, insert/remove, reg map, faults, events, i2c
  localparam int run_cycles = 16 + 40 + (deb + 60) + 160 + (deb + 40) + retries * (hold + 20)
                              + (hold + 40) + 2 * (deb + 60) + 40;
  localparam int limit_cycles = 2 * run_cycles;  // margin

  logic       clk;
  logic       reset;
  logic       los;
  logic       mod0_prsnt_n;
  logic       tx_fault;
  logic       tx_disable;
  logic [1:0] ratesel;
  tri1        mod1_scl;      // module side pull-ups
  tri1        mod2_sda;
  logic [3:0] mm_address;
  logic       mm_read;
  logic       mm_write;
  logic [7:0] mm_writedata;
  logic [7:0] mm_readdata;
  logic [1:0] mm_response;
  logic       scl_in;
  logic       sda_in;
  logic       scl_oe;
  logic       sda_oe;
  logic [3:0] test_id;
  int         err_count;
  int         seed;
  int         i;
  logic [7:0] wdata;

  sfp_port_top UUT (.*);

  sfp_port_checker CHK (.*);

  always #10 clk = ~clk;  // 20 ns

  task automatic reg_write(input logic [3:0] addr, input logic [7:0] data);
    @(negedge clk);
    mm_address   = addr;
    mm_writedata = data;
    mm_write     = 1'b1;
    @(negedge clk);
    mm_write = 1'b0;
  endtask

  // strobe held two cycles, checker samples the response on the second
  task automatic reg_read(input logic [3:0] addr);
    @(negedge clk);
    mm_address = addr;
    mm_read    = 1'b1;
    @(negedge clk);
    @(negedge clk);
    mm_read = 1'b0;
  endtask

  task automatic idle(input int n);
    repeat (n) @(negedge clk);
  endtask

  // port reports active by letting the laser on, needs tx_disable_req low
  task automatic wait_laser_on(input int max_cycles);
    int n;
    n = 0;
    while (tx_disable && n < max_cycles)
    begin
      @(negedge clk);
      n++;
    end
    if (tx_disable)
      CHK.note_failure("timed out waiting for tx_disable to fall");
  endtask

  task automatic set_present(input logic on);
    @(negedge clk);
    mod0_prsnt_n = ~on;
  endtask

  task automatic pulse_fault();
    @(negedge clk);
    tx_fault = 1'b1;
    idle(4);
    tx_fault = 1'b0;
  endtask

  initial
  begin
    seed         = 32'h1a4b640f;
    clk          = 1'b0;
    reset        = 1'b1;
    los          = 1'b0;
    mod0_prsnt_n = 1'b1;  // cage empty
    tx_fault     = 1'b0;
    mm_address   = 4'h0;
    mm_read      = 1'b0;
    mm_write     = 1'b0;
    mm_writedata = 8'h00;
    scl_oe       = 1'b0;
    sda_oe       = 1'b0;
    test_id      = 4'd0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    test_id = 4'd1;
    idle(4);  // let the sync stages settle
    reg_read(reg_state);
    reg_read(reg_status);
    reg_read(reg_control);
    reg_read(reg_events);

    test_id = 4'd2;
    reg_write(reg_control, 8'h00);
    set_present(1'b1);
    wait_laser_on(deb + 10);
    idle(2);
    reg_read(reg_state);
    reg_read(reg_status);
    reg_write(reg_control, 8'h08);  // laser off by sw
    reg_read(reg_status);
    reg_write(reg_control, 8'h00);
    reg_read(reg_status);
    set_present(1'b0);
    idle(6);
    reg_read(reg_state);
    reg_read(reg_events);
    reg_read(reg_status);

    test_id = 4'd3;
    for (i = 0; i < 8; i++)
    begin
      wdata = $random(seed);
      reg_write(reg_control, wdata);
      reg_read(reg_control);
      reg_read(reg_status);
    end
    for (i = 4; i < 16; i++)
    begin
      wdata = $random(seed);
      reg_write(i[3:0], wdata);
      reg_read(i[3:0]);
    end

    test_id = 4'd4;
    reg_write(reg_control, 8'h00);
    set_present(1'b1);
    wait_laser_on(deb + 10);
    for (i = 1; i <= retries; i++)
    begin
      pulse_fault();
      if (i < retries)
      begin
        wait_laser_on(hold + 12);
        idle(2);
        reg_read(reg_state);
      end
    end
    idle(hold + 8);  // last fault ends in lockout
    reg_read(reg_state);
    reg_read(reg_status);
    reg_write(reg_control, 8'h01);  // fault_clear
    wait_laser_on(deb + 10);
    idle(2);
    reg_read(reg_state);

    test_id = 4'd5;
    reg_read(reg_events);
    reg_write(reg_events, 8'h02);  // clear removed only
    reg_read(reg_events);
    @(negedge clk);
    los = 1'b1;
    idle(6);
    reg_read(reg_events);
    reg_read(reg_status);
    reg_write(reg_events, 8'h04);
    reg_read(reg_events);
    los = 1'b0;
    set_present(1'b0);
    idle(6);
    set_present(1'b1);
    wait_laser_on(deb + 10);
    idle(2);
    reg_read(reg_events);
    reg_write(reg_events, 8'h0f);
    reg_read(reg_events);

    test_id = 4'd6;
    for (i = 0; i < 5; i++)
    begin
      @(negedge clk);
      scl_oe = (i == 1) || (i == 3);
      sda_oe = (i == 2) || (i == 3);
      idle(2);
    end

    idle(4);
    CHK.print_summary();
    if (err_count == 0)
      $display("** PASS **");
    else
      $display("** FAIL **");
    $finish;
  end

  // watchdog
  initial
  begin
    repeat (limit_cycles) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", limit_cycles);
    CHK.print_summary();
    $display("** FAIL **");
    $finish;
  end

endmodule

// File: build.f
+incdir+include
design/sfp_pkg.sv
design/sfp_ctrl_if.sv
design/sfp_input_sync.sv
design/sfp_port_timer.sv
design/sfp_port_fsm.sv
design/sfp_port_regs.sv
design/sfp_port_top.sv
sim/sfp_port_checker.sv
sim/sfp_port_tb.sv

// File: Bender.yml
package:
  name: sfp_port

sources:
  - include_dirs:
      - include
    files:
      - design/sfp_pkg.sv
      - design/sfp_ctrl_if.sv
      - design/sfp_input_sync.sv
      - design/sfp_port_timer.sv
      - design/sfp_port_fsm.sv
      - design/sfp_port_regs.sv
      - design/sfp_port_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/sfp_port_checker.sv
      - sim/sfp_port_tb.sv
